// ==== rtl/ex.sv ====
`timescale 1ns/100ps
`include "rv_core_cfg.svh"

module ex import rv_core_pkg::*; (
    input  logic   clk_i,
    input  logic   rst_i,
    input  issue_s issue_i,
    output wb_s    ex_fwd_o,   // unregistered, for the decode bypass
    output wb_s    wb_o
);

    issue_s           issue_q;
    wb_s              wb_q;
    logic [`XLEN-1:0] alu_res;

    // decode -> execute
    always_ff @(posedge clk_i) begin : issue_reg
        issue_q <= issue_i;
        if (rst_i) begin
            issue_q.valid <= 1'b0;  // only the valid bit needs clearing
        end
    end

    always_comb begin : alu
        case (issue_q.alu_op)
            ALU_ADD: alu_res = issue_q.op1 + issue_q.op2;
            ALU_SUB: alu_res = issue_q.op1 - issue_q.op2;  // wraps mod 2^32
            ALU_XOR: alu_res = issue_q.op1 ^ issue_q.op2;
            ALU_OR:  alu_res = issue_q.op1 | issue_q.op2;
            ALU_AND: alu_res = issue_q.op1 & issue_q.op2;
            default: alu_res = '0;
        endcase
    end

    // bubbles and x0 targets never look valid downstream
    always_comb begin : result
        ex_fwd_o.valid = issue_q.valid & issue_q.wreg;
        ex_fwd_o.rd    = issue_q.rd;
        ex_fwd_o.data  = alu_res;
    end

    // execute -> write-back
    always_ff @(posedge clk_i) begin : wb_reg
        wb_q <= ex_fwd_o;
        if (rst_i) begin
            wb_q.valid <= 1'b0;
        end
    end

    assign wb_o = wb_q;

endmodule

// ==== rtl/fetch.sv ====
`timescale 1ns/100ps
`include "rv_core_cfg.svh"

module fetch import rv_core_pkg::*; (
    input  logic             clk_i,
    input  logic             rst_i,
    input  inst_u            inst_i,       // word for the address of the previous cycle
    output logic [`XLEN-1:0] inst_addr_o,
    output fetch_s           fetch_o
);

    logic [`XLEN-1:0] pc_q;
    logic [`XLEN-1:0] req_pc_q;       // address whose word is on inst_i now
    logic             req_vld_q;
    fetch_s           fetch_q;

    // no branches, so the pc only ever steps forward
    always_ff @(posedge clk_i) begin : pc_reg
        if (rst_i) begin
            pc_q <= `RESET_PC;
        end else begin
            pc_q <= pc_q + `XLEN'd4;
        end
    end

    // memory read is synchronous, the word comes back one cycle later
    always_ff @(posedge clk_i) begin : req_reg
        req_pc_q <= pc_q;
        if (rst_i) begin
            req_vld_q <= 1'b0;
        end else begin
            req_vld_q <= 1'b1;
        end
    end

    // pair the returned word with the pc that asked for it
    always_ff @(posedge clk_i) begin : fetch_reg
        fetch_q.pc   <= req_pc_q;
        fetch_q.inst <= inst_i;
        if (rst_i) begin
            fetch_q.valid <= 1'b0;
        end else begin
            fetch_q.valid <= req_vld_q;  // one new word every cycle
        end
    end

    assign inst_addr_o = pc_q;
    assign fetch_o     = fetch_q;

endmodule

// ==== rtl/id.sv ====
`timescale 1ns/100ps
`include "rv_core_cfg.svh"

module id import rv_core_pkg::*; (
    input  fetch_s                 fetch_i,
    input  logic [`XLEN-1:0]       reg1_data_i,
    input  logic [`XLEN-1:0]       reg2_data_i,
    input  wb_s                    ex_fwd_i,     // result still in execute
    input  wb_s                    wb_fwd_i,     // result in the write-back register

    output logic                   reg1_read_o,
    output logic                   reg2_read_o,
    output logic [`REG_ADDR_W-1:0] reg1_addr_o,
    output logic [`REG_ADDR_W-1:0] reg2_addr_o,
    output issue_s                 issue_o
);

    inst_u            inst;
    logic [`XLEN-1:0] imm;
    logic             use_imm;
    logic             wreg;
    alu_op_e          alu_op;

    // newest producer wins, x0 is never taken from the bypass
    function automatic logic [`XLEN-1:0] fwd_sel(
        input logic [`REG_ADDR_W-1:0] addr,
        input logic [`XLEN-1:0]       rf_data,
        input wb_s                    ex_src,
        input wb_s                    wb_src
    );
        logic [`XLEN-1:0] val;
        if (addr == '0) begin
            val = rf_data;
        end else if (ex_src.valid && (ex_src.rd == addr)) begin
            val = ex_src.data;
        end else if (wb_src.valid && (wb_src.rd == addr)) begin
            val = wb_src.data;
        end else begin
            val = rf_data;
        end
        return val;
    endfunction

    assign inst = fetch_i.inst;

    // source fields sit in the same place for both formats
    assign reg1_addr_o = inst.r_fmt.rs1;
    assign reg2_addr_o = inst.r_fmt.rs2;

    assign imm = {{(`XLEN-12){inst.i_fmt.imm12[11]}}, inst.i_fmt.imm12};  // sign extend

    always_comb begin : decode
        reg1_read_o = 1'b0;
        reg2_read_o = 1'b0;
        use_imm     = 1'b0;
        wreg        = 1'b0;
        alu_op      = ALU_ADD;

        case (inst.r_fmt.opcode)
            `OPC_OP_IMM: begin
                reg1_read_o = 1'b1;
                use_imm     = 1'b1;  // imm12 takes the rs2 slot
                wreg        = 1'b1;
                case (inst.i_fmt.funct3)
                    `F3_ADD: alu_op = ALU_ADD;
                    `F3_XOR: alu_op = ALU_XOR;
                    `F3_OR:  alu_op = ALU_OR;
                    `F3_AND: alu_op = ALU_AND;
                    default: wreg   = 1'b0;  // shifts and compares not built
                endcase
            end
            `OPC_OP: begin
                reg1_read_o = 1'b1;
                reg2_read_o = 1'b1;
                wreg        = 1'b1;
                case (inst.r_fmt.funct3)
                    `F3_ADD: alu_op = (inst.r_fmt.funct7 == `F7_SUB) ? ALU_SUB : ALU_ADD;
                    `F3_XOR: alu_op = ALU_XOR;
                    `F3_OR:  alu_op = ALU_OR;
                    `F3_AND: alu_op = ALU_AND;
                    default: wreg   = 1'b0;
                endcase
            end
            default: begin
                // anything else passes down as a bubble
            end
        endcase
    end

    always_comb begin : operands
        issue_o.valid  = fetch_i.valid;
        issue_o.alu_op = alu_op;
        issue_o.rd     = inst.r_fmt.rd;
        issue_o.wreg   = wreg && (inst.r_fmt.rd != '0);  // x0 writes are dropped here

        if (reg1_read_o) begin
            issue_o.op1 = fwd_sel(reg1_addr_o, reg1_data_i, ex_fwd_i, wb_fwd_i);
        end else begin
            issue_o.op1 = '0;
        end

        if (use_imm) begin
            issue_o.op2 = imm;
        end else if (reg2_read_o) begin
            issue_o.op2 = fwd_sel(reg2_addr_o, reg2_data_i, ex_fwd_i, wb_fwd_i);
        end else begin
            issue_o.op2 = '0;
        end
    end

endmodule

// ==== rtl/regfile.sv ====
`timescale 1ns/100ps
`include "rv_core_cfg.svh"

module regfile import rv_core_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rst_i,

    input  logic                   reg1_read_i,
    input  logic                   reg2_read_i,
    input  logic [`REG_ADDR_W-1:0] reg1_addr_i,
    input  logic [`REG_ADDR_W-1:0] reg2_addr_i,
    output logic [`XLEN-1:0]       reg1_data_o,
    output logic [`XLEN-1:0]       reg2_data_o,

    input  wb_s                    wb_i          // single write port
);

    logic [`XLEN-1:0] regs_q [`REG_NUM];

    always_ff @(posedge clk_i) begin : write_port
        if (rst_i) begin
            for (int i = 0; i < `REG_NUM; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wb_i.valid && (wb_i.rd != '0)) begin
            regs_q[wb_i.rd] <= wb_i.data;
        end
    end

    // reads are asynchronous
    // same-cycle writes are covered by the bypass in decode
    always_comb begin : read_ports
        if (reg1_read_i && (reg1_addr_i != '0)) begin
            reg1_data_o = regs_q[reg1_addr_i];
        end else begin
            reg1_data_o = '0;
        end

        if (reg2_read_i && (reg2_addr_i != '0)) begin
            reg2_data_o = regs_q[reg2_addr_i];
        end else begin
            reg2_data_o = '0;
        end
    end

endmodule

// ==== rtl/rv_core.sv ====
`timescale 1ns/100ps
`include "rv_core_cfg.svh"

module rv_core import rv_core_pkg::*; (
    input  logic             clk_i,
    input  logic             rst_i,

    // instruction memory, word returned one cycle after its address
    output logic [`XLEN-1:0] inst_addr_o,
    input  inst_u            inst_i,

    // retired register writes
    output wb_s              wb_o
);

    fetch_s                 fetch;
    issue_s                 issue;
    wb_s                    ex_fwd;
    wb_s                    wb;

    logic                   reg1_read;
    logic                   reg2_read;
    logic [`REG_ADDR_W-1:0] reg1_addr;
    logic [`REG_ADDR_W-1:0] reg2_addr;
    logic [`XLEN-1:0]       reg1_data;
    logic [`XLEN-1:0]       reg2_data;

    fetch u_fetch (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .inst_i      (inst_i),
        .inst_addr_o (inst_addr_o),
        .fetch_o     (fetch)
    );

    id u_id (
        .fetch_i     (fetch),
        .reg1_data_i (reg1_data),
        .reg2_data_i (reg2_data),
        .ex_fwd_i    (ex_fwd),
        .wb_fwd_i    (wb),        // same value the regfile is about to take
        .reg1_read_o (reg1_read),
        .reg2_read_o (reg2_read),
        .reg1_addr_o (reg1_addr),
        .reg2_addr_o (reg2_addr),
        .issue_o     (issue)
    );

    regfile u_regfile (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .reg1_read_i (reg1_read),
        .reg2_read_i (reg2_read),
        .reg1_addr_i (reg1_addr),
        .reg2_addr_i (reg2_addr),
        .reg1_data_o (reg1_data),
        .reg2_data_o (reg2_data),
        .wb_i        (wb)
    );

    ex u_ex (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .issue_i     (issue),
        .ex_fwd_o    (ex_fwd),
        .wb_o        (wb)
    );

    assign wb_o = wb;

endmodule

// ==== rtl/rv_core_cfg.svh ====
`ifndef RV_CORE_CFG_SVH
`define RV_CORE_CFG_SVH

// datapath sizing
`define XLEN        32
`define REG_ADDR_W  5
`define REG_NUM     32

// first fetch address after reset
`define RESET_PC    32'h0000_0000

// major opcodes, inst[6:0]
`define OPC_OP_IMM  7'b0010011  // addi xori ori andi
`define OPC_OP      7'b0110011  // add sub xor or and

// funct3, inst[14:12]
`define F3_ADD      3'b000      // add/sub share this code
`define F3_XOR      3'b100
`define F3_OR       3'b110
`define F3_AND      3'b111

// funct7, inst[31:25]
// only bit 30 matters here, it turns add into sub
`define F7_SUB      7'b0100000

`endif

// ==== rtl/rv_core_pkg.sv ====
`include "rv_core_cfg.svh"

package rv_core_pkg;

    // register-register layout
    typedef struct packed {
        logic [6:0]             funct7;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } r_fmt_s;

    // register-immediate layout
    typedef struct packed {
        logic [11:0]            imm12;  // sign bit is inst[31]
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } i_fmt_s;

    // one instruction word, two readings of the upper bits
    typedef union packed {
        r_fmt_s r_fmt;
        i_fmt_s i_fmt;
    } inst_u;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_XOR = 3'd2,
        ALU_OR  = 3'd3,
        ALU_AND = 3'd4
    } alu_op_e;

    // fetch -> decode
    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] pc;
        inst_u            inst;
    } fetch_s;

    // decode -> execute, operands already resolved
    typedef struct packed {
        logic                   valid;
        alu_op_e                alu_op;
        logic [`XLEN-1:0]       op1;
        logic [`XLEN-1:0]       op2;
        logic [`REG_ADDR_W-1:0] rd;
        logic                   wreg;   // result goes to rd
    } issue_s;

    // register write, also used as a forwarding source
    typedef struct packed {
        logic                   valid;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       data;
    } wb_s;

endpackage

// ==== run_sim.sh ====
#!/bin/sh
# build with verilator, run, then judge the result from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal --timescale 1ns/100ps \
    --top-module rv_core_tb -f rv_core.f -o rv_core_sim \
    && ./obj_dir/rv_core_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }

cat sim.log
grep -q "test failed" sim.log && exit 1
grep -q "test passed" sim.log || exit 1
exit 0

// ==== rv_core.f ====
+incdir+rtl
rtl/rv_core_pkg.sv
rtl/fetch.sv
rtl/regfile.sv
rtl/id.sv
rtl/ex.sv
rtl/rv_core.sv
verif/rv_core_tb.sv

// ==== verif/rv_core_tb.sv ====
`timescale 1ns/100ps
`include "rv_core_cfg.svh"

module rv_core_tb import rv_core_pkg::*; ();

    localparam int CLK_PERIOD     = 100;
    localparam int RESET_CYCLES   = 10;
    localparam int FIRST_WB_EDGES = 4;    // address, fetch, issue, write-back edges
    localparam int ROM_AW         = 6;
    localparam inst_u NOP_WORD    = inst_u'({12'h000, 5'd0, `F3_ADD, 5'd0, `OPC_OP_IMM});

    typedef struct packed {
        inst_u                  inst;
        logic                   wr;       // retires with a register write
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       data;
    } entry_s;

    logic             clk_i;
    logic             rst_i;
    inst_u            inst_i;
    logic [`XLEN-1:0] inst_addr_o;
    wb_s              wb_o;

    entry_s           tab [$];
    string            group_name [$];
    int               group_end [$];
    inst_u            rom [1 << ROM_AW];
    logic [`XLEN-1:0] rom_addr_q;     // address seen one cycle earlier
    integer           seed;
    bit               table_ready;
    int               pass_cnt;
    int               fail_cnt;

    rv_core dut_i (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .inst_addr_o (inst_addr_o),
        .inst_i      (inst_i),
        .wb_o        (wb_o)
    );

    initial begin : clock_gen
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    function automatic inst_u enc_i(input logic [2:0] f3, input logic [4:0] rd, rs1,
                                    input logic [11:0] imm);
        return inst_u'({imm, rs1, f3, rd, `OPC_OP_IMM});
    endfunction

    function automatic inst_u enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                    input logic [4:0] rd, rs1, rs2);
        return inst_u'({f7, rs2, rs1, f3, rd, `OPC_OP});
    endfunction

    // sign > 0 gives a positive imm12, sign < 0 a negative one
    function automatic logic [11:0] rimm(input int sign);
        logic [31:0] r;
        r = $random(seed);
        if (sign > 0) r[11] = 1'b0;
        if (sign < 0) r[11] = 1'b1;
        return r[11:0];
    endfunction

    task automatic push_inst(input inst_u w);
        entry_s e;
        e      = '0;
        e.inst = w;
        tab.push_back(e);
    endtask

    task automatic close_group(input string name);
        group_name.push_back(name);
        group_end.push_back(tab.size() - 1);
    endtask

    task automatic build_program();
        push_inst(enc_i(`F3_ADD, 5'd1, 5'd0, rimm(1)));
        push_inst(enc_i(`F3_ADD, 5'd2, 5'd0, rimm(-1)));
        push_inst(enc_i(`F3_XOR, 5'd3, 5'd1, rimm(-1)));
        push_inst(enc_i(`F3_OR,  5'd4, 5'd2, rimm(1)));
        push_inst(enc_i(`F3_AND, 5'd5, 5'd2, rimm(-1)));
        push_inst(enc_i(`F3_ADD, 5'd6, 5'd0, 12'hfff));                // x6 = -1
        close_group("reset and immediate ops");
        push_inst(enc_i(`F3_ADD, 5'd7, 5'd0, rimm(0)));
        push_inst(enc_i(`F3_ADD, 5'd8, 5'd0, rimm(0)));
        push_inst(NOP_WORD);
        push_inst(NOP_WORD);                           // x7 and x8 read from the regfile
        push_inst(enc_r(7'd0,    `F3_ADD, 5'd9,  5'd7, 5'd8));
        push_inst(enc_r(`F7_SUB, `F3_ADD, 5'd10, 5'd2, 5'd1));
        push_inst(enc_r(`F7_SUB, `F3_ADD, 5'd11, 5'd0, 5'd1));     // wraps below zero
        push_inst(enc_r(7'd0,    `F3_XOR, 5'd12, 5'd7, 5'd8));
        push_inst(enc_r(7'd0,    `F3_OR,  5'd13, 5'd2, 5'd7));
        push_inst(enc_r(7'd0,    `F3_AND, 5'd14, 5'd6, 5'd8));
        close_group("register ops");
        push_inst(enc_i(`F3_ADD, 5'd15, 5'd0, rimm(0)));
        push_inst(enc_i(`F3_ADD, 5'd15, 5'd15, rimm(0)));             // distance 1
        push_inst(enc_r(7'd0,    `F3_ADD, 5'd16, 5'd15, 5'd15));   // x15 in ex and in wb
        push_inst(enc_i(`F3_XOR, 5'd17, 5'd15, rimm(-1)));            // distance 2
        push_inst(enc_r(`F7_SUB, `F3_ADD, 5'd18, 5'd16, 5'd17));
        push_inst(enc_r(7'd0,    `F3_OR,  5'd19, 5'd18, 5'd16));
        push_inst(enc_r(7'd0,    `F3_AND, 5'd20, 5'd19, 5'd18));
        close_group("forwarding");
        push_inst(enc_i(`F3_ADD, 5'd0, 5'd1, rimm(0)));
        push_inst(enc_r(7'd0,    `F3_ADD, 5'd21, 5'd0, 5'd1));     // x0 right after the write
        push_inst(enc_r(7'd0,    `F3_XOR, 5'd0, 5'd7, 5'd8));
        push_inst(enc_i(`F3_ADD, 5'd22, 5'd0, rimm(0)));
        push_inst(enc_r(7'd0,    `F3_OR,  5'd23, 5'd0, 5'd22));
        close_group("x0 handling");
        push_inst(inst_u'({20'h5a5a5, 5'd24, 7'b0110111}));                // lui
        push_inst(enc_i(`F3_ADD, 5'd25, 5'd24, rimm(0)));
        push_inst(inst_u'({12'h004, 5'd1, 3'b010, 5'd25, 7'b0000011}));    // lw
        push_inst(enc_i(3'b001, 5'd26, 5'd1, 12'h003));                    // slli
        push_inst(enc_r(7'd0,    `F3_XOR, 5'd27, 5'd26, 5'd25));
        push_inst(enc_r(7'd0,    `F3_ADD, 5'd28, 5'd27, 5'd1));
        close_group("unsupported opcodes");
    endtask

    // architectural model, program order with no notion of pipeline distance
    task automatic compute_expected();
        logic [`XLEN-1:0] regs [32];
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        logic [`XLEN-1:0] res;
        logic             is_op;
        logic             ok;
        entry_s           e;
        for (int i = 0; i < 32; i++) regs[i] = '0;
        for (int k = 0; k < tab.size(); k++) begin
            e     = tab[k];
            is_op = (e.inst.r_fmt.opcode == `OPC_OP);
            ok    = is_op || (e.inst.r_fmt.opcode == `OPC_OP_IMM);
            a     = regs[e.inst.r_fmt.rs1];
            b     = is_op ? regs[e.inst.r_fmt.rs2] : 32'($signed(e.inst.i_fmt.imm12));
            res   = '0;
            case (e.inst.r_fmt.funct3)
                `F3_ADD: res = (is_op && e.inst.r_fmt.funct7 == `F7_SUB) ? a - b : a + b;
                `F3_XOR: res = a ^ b;
                `F3_OR:  res = a | b;
                `F3_AND: res = a & b;
                default: ok  = 1'b0;
            endcase
            e.wr   = ok && (e.inst.r_fmt.rd != '0);
            e.rd   = e.inst.r_fmt.rd;
            e.data = res;
            if (e.wr) regs[e.rd] = res;
            tab[k] = e;
        end
    endtask

    // word index is pc / 4, beyond the loaded words only nops
    function automatic inst_u rom_read(input logic [`XLEN-1:0] addr);
        logic [`XLEN-1:0] idx;
        idx = addr >> 2;
        if (idx < (1 << ROM_AW)) return rom[idx[ROM_AW-1:0]];
        return NOP_WORD;
    endfunction

    // synchronous read, the word follows its address by one cycle
    always @(negedge clk_i) begin : rom_model
        inst_i     <= rom_read(rom_addr_q);
        rom_addr_q <= inst_addr_o;
    end

    initial begin : watchdog
        int limit;
        wait (table_ready);
        limit = RESET_CYCLES + tab.size() + 20;
        repeat (limit) @(posedge clk_i);
        $display("watchdog: write-backs stopped arriving, run ended after %0d cycles", limit);
        $display("test failed");
        $finish;
    end

    initial begin : main
        int     cyc;
        int     g;
        int     grp_base;
        entry_s e;
        seed        = 55;
        table_ready = 1'b0;
        pass_cnt    = 0;
        fail_cnt    = 0;
        rst_i       = 1'b1;
        inst_i      = NOP_WORD;
        rom_addr_q  = `RESET_PC;
        build_program();
        compute_expected();
        for (int i = 0; i < (1 << ROM_AW); i++) begin
            rom[i] = (i < tab.size()) ? tab[i].inst : NOP_WORD;
        end
        table_ready = 1'b1;

        // pipeline empty and pc parked while reset is held
        repeat (RESET_CYCLES) begin
            @(negedge clk_i);
            if (wb_o.valid !== 1'b0 || inst_addr_o !== `RESET_PC) begin
                $display("Mismatch wb_o.valid/inst_addr_o in reset: %s 0x0/0x%h, got 0x%h/0x%h",
                         "expected", `RESET_PC, wb_o.valid, inst_addr_o);
                fail_cnt++;
            end else begin
                pass_cnt++;
            end
        end
        rst_i = 1'b0;

        cyc      = 0;   // falling edges since reset release
        g        = 0;
        grp_base = 0;
        for (int k = 0; k < tab.size(); k++) begin
            e = tab[k];
            if (e.wr) begin
                do begin
                    @(negedge clk_i);
                    cyc++;
                end while (wb_o.valid !== 1'b1);
                if (cyc != k + FIRST_WB_EDGES) begin
                    $display("entry %0d wrote back on cycle %0d, expected cycle %0d",
                             k, cyc, k + FIRST_WB_EDGES);
                    fail_cnt++;
                end else begin
                    pass_cnt++;
                end
                if (wb_o.rd !== e.rd) begin
                    $display("Mismatch wb_o.rd entry %0d: expected 0x%h, got 0x%h",
                             k, e.rd, wb_o.rd);
                    fail_cnt++;
                end else begin
                    pass_cnt++;
                end
                if (wb_o.data !== e.data) begin
                    $display("Mismatch wb_o.data entry %0d: expected 0x%h, got 0x%h",
                             k, e.data, wb_o.data);
                    fail_cnt++;
                end else begin
                    pass_cnt++;
                end
            end
            if (k == group_end[g]) begin
                if (fail_cnt == grp_base) $display("%s: ok", group_name[g]);
                else $display("%s: %0d errors", group_name[g], fail_cnt - grp_base);
                grp_base = fail_cnt;
                g++;
            end
        end

        // nop fill after the table must stay silent
        repeat (4) begin
            @(negedge clk_i);
            if (wb_o.valid !== 1'b0) begin
                $display("a write-back appeared after the last table entry had retired");
                fail_cnt++;
            end
        end

        $display("checks: %0d passed, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule
